//--- common/source_settings.svh
// load engine configuration macros for port count and datapath widths
`ifndef SOURCE_SETTINGS_SVH
`define SOURCE_SETTINGS_SVH

// memory ports and 32-bit words per output beat
`define SRC_NB_PORTS 2

// width of one memory word
`define SRC_WORD_W 32

// byte address width
`define SRC_ADDR_W 32

// width of the transaction counter and of trans_size
`define SRC_TRANS_CNT_W 16

`endif

//--- common/source_pkg.sv
// load engine package, FSM state, word, address and count types
`include "source_settings.svh"

package source_pkg;

  // control FSM state, one bit is enough in coupled mode
  typedef enum logic {
    STREAM_IDLE    = 1'b0, // waiting for start
    STREAM_WORKING = 1'b1  // issuing loads
  } state_e;

  // one memory word as returned by a port
  typedef logic [`SRC_WORD_W-1:0] word_t;

  // byte address on the memory side
  typedef logic [`SRC_ADDR_W-1:0] addr_t;

  // number of wide words in a job
  typedef logic [`SRC_TRANS_CNT_W-1:0] count_t;

endpackage

//--- src/source_fsm.sv
// control FSM, accepts start, issues the load bursts and flags done
`timescale 1ns/1ps
`include "source_settings.svh"

module source_fsm (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     clear_i,
  input  logic                     start_i,
  input  logic                     ready_i,       // consumer ready, gates requests
  input  logic [`SRC_NB_PORTS-1:0] mem_gnt_i,
  input  logic                     in_progress_i, // from address generator
  output logic [`SRC_NB_PORTS-1:0] mem_req_o,
  output logic                     ag_load_o,
  output logic                     ag_enable_o,
  output logic                     ready_start_o,
  output logic                     done_o
);

  source_pkg::state_e cs, ns;

  logic req;       // load burst requested this cycle
  logic gnt;       // all ports granted
  logic done_d;    // final grant seen
  logic done_q;

  // memory grants all ports or none, AND them anyway
  assign gnt       = &mem_gnt_i;
  assign mem_req_o = {`SRC_NB_PORTS{req}};
  assign done_o    = done_q;

  always_comb begin
    ns            = cs;
    req           = 1'b0;
    ag_load_o     = 1'b0;
    ag_enable_o   = 1'b0;
    ready_start_o = 1'b0;
    done_d        = 1'b0;
    case (cs)
      source_pkg::STREAM_IDLE: begin
        ready_start_o = 1'b1;
        if (start_i) begin
          ag_load_o = 1'b1;    // sample base and size now
          ns        = source_pkg::STREAM_WORKING;
        end
      end
      source_pkg::STREAM_WORKING: begin
        // no new load while the consumer stalls
        req = ready_i;
        if (req && gnt) begin
          if (in_progress_i) begin
            ag_enable_o = 1'b1;  // step to next wide word
          end else begin
            done_d = 1'b1;       // last word granted
            ns     = source_pkg::STREAM_IDLE;
          end
        end
      end
      default: begin
        ns = source_pkg::STREAM_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cs     <= source_pkg::STREAM_IDLE;
      done_q <= 1'b0;
    end else if (clear_i) begin
      cs     <= source_pkg::STREAM_IDLE;
      done_q <= 1'b0;
    end else begin
      cs     <= ns;
      done_q <= done_d;  // one cycle after final grant
    end
  end

  // memory side contract, grants come for every port or for none
  a_gnt_all_or_none : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (|mem_req_o) |-> (mem_gnt_i == '0 || mem_gnt_i == '1)
  ) else $error("memory granted only a subset of the ports");

  // done is a single-cycle pulse
  a_done_pulse : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    done_o |=> !done_o
  ) else $error("done held for more than one cycle");

endmodule

//--- src/source_addressgen.sv
// linear address generator, unit-stride walk over wide words with a transaction counter
`timescale 1ns/1ps
`include "source_settings.svh"

module source_addressgen (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               clear_i,
  input  logic               load_i,        // take base and size on start
  input  logic               enable_i,      // step on each granted wide word
  input  source_pkg::addr_t  base_addr_i,
  input  source_pkg::count_t trans_size_i,  // wide words in the job, at least one
  output source_pkg::addr_t  addr_o,
  output logic               in_progress_o  // more words after the current one
);

  // byte distance between consecutive wide words
  localparam int unsigned STEP = `SRC_NB_PORTS * 4;

  source_pkg::addr_t  addr_q;   // current wide-word address
  source_pkg::count_t size_q;   // job size as sampled at start
  source_pkg::count_t cnt_q;    // words already stepped over
  logic               loaded_q; // a job config is held
  logic               last_word;

  // current word is the final one of the job
  assign last_word = (cnt_q >= size_q - source_pkg::count_t'(1));

  assign addr_o        = addr_q;
  assign in_progress_o = loaded_q & ~last_word;

  // address and size latched on load, address stepped on enable
  always_ff @(posedge clk_i) begin
    if (load_i) begin
      addr_q <= base_addr_i;
      size_q <= trans_size_i;
    end else if (enable_i) begin
      addr_q <= addr_q + source_pkg::addr_t'(STEP); // next wide word
    end
  end

  // job counter and loaded flag
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q    <= '0;
      loaded_q <= 1'b0;
    end else if (clear_i) begin
      cnt_q    <= '0;
      loaded_q <= 1'b0;
    end else if (load_i) begin
      cnt_q    <= '0;   // fresh job
      loaded_q <= 1'b1;
    end else if (enable_i) begin
      cnt_q    <= cnt_q + source_pkg::count_t'(1);
    end
  end

  // the FSM stops stepping once the final word is reached;
  // the last grant ends the job instead of enabling
  a_no_step_past_end : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (enable_i && loaded_q) |-> in_progress_o
  ) else $error("address generator enabled past the last wide word");

  // a load and a step never coincide as the FSM loads only in idle
  a_load_not_enable : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    load_i |-> !enable_i
  ) else $error("address generator loaded and enabled together");

endmodule

//--- src/load_port_buffer.sv
// per-port response buffer, passes a read word through or holds it until taken
`timescale 1ns/1ps
`include "source_settings.svh"

module load_port_buffer (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              clear_i,
  input  logic              rvalid_i,     // response from memory
  input  source_pkg::word_t rdata_i,
  input  logic              word_ready_i, // merge took the beat
  output logic              word_valid_o,
  output source_pkg::word_t word_o
);

  logic              valid_q; // word held
  source_pkg::word_t data_q;  // last response seen

  // bypass the fresh response, else replay the held one
  assign word_valid_o = rvalid_i | valid_q;
  assign word_o       = rvalid_i ? rdata_i : data_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (clear_i) begin
      valid_q <= 1'b0;
    end else begin
      if (rvalid_i && word_ready_i)
        valid_q <= 1'b0;      // taken in the same cycle
      else if (rvalid_i)
        valid_q <= 1'b1;      // keep it for later
      else if (valid_q && word_ready_i)
        valid_q <= 1'b0;      // held word taken
    end
  end

  // capture every response, only read back while valid_q
  always_ff @(posedge clk_i) begin
    if (rvalid_i)
      data_q <= rdata_i;
  end

  // requests stop while the consumer stalls, so a second
  // response never lands on top of a held one
  a_no_overwrite : assert property (
    @(posedge clk_i) disable iff (!rst_ni || clear_i)
    rvalid_i |-> !valid_q
  ) else $error("response arrived while a word is held");

endmodule

//--- src/word_merge.sv
// word merge, joins the port words into one wide beat under valid/ready
`timescale 1ns/1ps
`include "source_settings.svh"

module word_merge (
  input  logic                                  rst_ni,
  input  logic                                  clk_i,
  input  logic [`SRC_NB_PORTS-1:0]              word_valid_i,
  input  source_pkg::word_t [`SRC_NB_PORTS-1:0] word_i,
  input  logic                                  ready_i,   // consumer ready
  output logic                                  valid_o,
  output logic [`SRC_NB_PORTS*`SRC_WORD_W-1:0]  data_o,
  output logic [`SRC_NB_PORTS-1:0]              word_ready_o
);

  logic beat_hs; // output beat transfers

  // beat is valid only once every port has its word
  assign valid_o = &word_valid_i;
  assign beat_hs = valid_o & ready_i;

  // release all ports together, only on transfer
  assign word_ready_o = {`SRC_NB_PORTS{beat_hs}};

  // port 0 in the low word
  for (genvar p = 0; p < `SRC_NB_PORTS; p++) begin : gen_pack
    assign data_o[p*`SRC_WORD_W +: `SRC_WORD_W] = word_i[p];
  end

  // stream rule, relies on the port buffers holding their words
  a_valid_stable : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (valid_o && !ready_i) |=> (valid_o && $stable(data_o))
  ) else $error("output beat dropped or changed before transfer");

endmodule

//--- src/stream_source.sv
// load engine top, request side, per-port response buffers and word merge
`timescale 1ns/1ps
`include "source_settings.svh"

module stream_source (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   clear_i,
  // host control
  input  logic                                   start_i,
  input  source_pkg::addr_t                      base_addr_i,
  input  source_pkg::count_t                     trans_size_i,
  output logic                                   ready_start_o,
  output logic                                   done_o,
  // memory ports, all granted together
  output logic [`SRC_NB_PORTS-1:0]               mem_req_o,
  output source_pkg::addr_t [`SRC_NB_PORTS-1:0]  mem_addr_o,
  input  logic [`SRC_NB_PORTS-1:0]               mem_gnt_i,
  input  logic [`SRC_NB_PORTS-1:0]               mem_rvalid_i,
  input  source_pkg::word_t [`SRC_NB_PORTS-1:0]  mem_rdata_i,
  // output stream
  output logic                                   valid_o,
  output logic [`SRC_NB_PORTS*`SRC_WORD_W-1:0]   data_o,
  input  logic                                   ready_i
);

  logic                                  ag_load;      // latch job config
  logic                                  ag_enable;    // step to next wide word
  logic                                  ag_in_progress;
  source_pkg::addr_t                     ag_addr;      // wide-word base address
  logic [`SRC_NB_PORTS-1:0]              word_valid;
  logic [`SRC_NB_PORTS-1:0]              word_ready;
  source_pkg::word_t [`SRC_NB_PORTS-1:0] word;

  source_fsm i_source_fsm (
    .clk_i         ( clk_i          ),
    .rst_ni        ( rst_ni         ),
    .clear_i       ( clear_i        ),
    .start_i       ( start_i        ),
    .ready_i       ( ready_i        ),
    .mem_gnt_i     ( mem_gnt_i      ),
    .in_progress_i ( ag_in_progress ),
    .mem_req_o     ( mem_req_o      ),
    .ag_load_o     ( ag_load        ),
    .ag_enable_o   ( ag_enable      ),
    .ready_start_o ( ready_start_o  ),
    .done_o        ( done_o         )
  );

  source_addressgen i_source_addressgen (
    .clk_i         ( clk_i          ),
    .rst_ni        ( rst_ni         ),
    .clear_i       ( clear_i        ),
    .load_i        ( ag_load        ),
    .enable_i      ( ag_enable      ),
    .base_addr_i   ( base_addr_i    ),
    .trans_size_i  ( trans_size_i   ),
    .addr_o        ( ag_addr        ),
    .in_progress_o ( ag_in_progress )
  );

  for (genvar p = 0; p < `SRC_NB_PORTS; p++) begin : gen_port
    // port p reads the word 4*p bytes into the wide word
    assign mem_addr_o[p] = ag_addr + source_pkg::addr_t'(4 * p);

    load_port_buffer i_load_port_buffer (
      .clk_i        ( clk_i           ),
      .rst_ni       ( rst_ni          ),
      .clear_i      ( clear_i         ),
      .rvalid_i     ( mem_rvalid_i[p] ),
      .rdata_i      ( mem_rdata_i[p]  ),
      .word_ready_i ( word_ready[p]   ),
      .word_valid_o ( word_valid[p]   ),
      .word_o       ( word[p]         )
    );
  end

  word_merge i_word_merge (
    .rst_ni       ( rst_ni     ),
    .clk_i        ( clk_i      ),
    .word_valid_i ( word_valid ),
    .word_i       ( word       ),
    .ready_i      ( ready_i    ),
    .valid_o      ( valid_o    ),
    .data_o       ( data_o     ),
    .word_ready_o ( word_ready )
  );

endmodule

//--- test/tb_stream_source_tasks.svh
// directed tests and helpers for the load engine testbench
`ifndef TB_STREAM_SOURCE_TASKS_SVH
`define TB_STREAM_SOURCE_TASKS_SVH

  // X or Z in actual is a mismatch too
  task automatic check_value(input string name, input beat_t expected, input beat_t actual);
    if (actual !== expected) begin
      err_cnt++;
      $display("ERR %s expected %0h actual %0h at %0t", name, expected, actual, $time);
    end
  endtask

  // beat k of a job from base, port 0 in the low word
  function automatic beat_t expected_beat(input source_pkg::addr_t base, input int k);
    beat_t             beat;
    source_pkg::addr_t a;
    for (int p = 0; p < NB; p++) begin
      a = base + source_pkg::addr_t'(k * NB * 4 + 4 * p);
      beat[p*`SRC_WORD_W +: `SRC_WORD_W] = a ^ PATTERN;
    end
    return beat;
  endfunction

  task automatic start_job(input source_pkg::addr_t base, input source_pkg::count_t size);
    @(posedge clk_i);
    start_i      <= 1'b1;
    base_addr_i  <= base;
    trans_size_i <= size;
    @(posedge clk_i);
    while (!ready_start_o) @(posedge clk_i);  // accepted on this edge
    start_i <= 1'b0;
  endtask

  // full job, then count, done pulse and data against the reference
  task automatic run_job(input string name, input source_pkg::addr_t base,
                         input source_pkg::count_t size);
    int n0;
    int d0;
    n0 = got_q.size();
    d0 = done_cnt;
    start_job(base, size);
    while (got_q.size() < n0 + int'(size) || done_cnt == d0) @(posedge clk_i);
    repeat (8) @(posedge clk_i);  // a stray extra beat would show up here
    check_value({name, " beats"}, beat_t'(size), beat_t'(got_q.size() - n0));
    check_value({name, " done pulses"}, beat_t'(1), beat_t'(done_cnt - d0));
    check_value({name, " ready_start"}, beat_t'(1'b1), beat_t'(ready_start_o));
    for (int k = 0; k < int'(size) && n0 + k < got_q.size(); k++)
      check_value({name, " data"}, expected_beat(base, k), got_q[n0 + k]);
  endtask

  task automatic reset_outputs();
    check_value("reset ready_start", beat_t'(1'b1), beat_t'(ready_start_o));
    check_value("reset valid", '0, beat_t'(valid_o));
    check_value("reset done", '0, beat_t'(done_o));
    check_value("reset mem_req", '0, beat_t'(mem_req_o));
  endtask

  task automatic basic_jobs();
    run_job("single", 32'h0000_1000, 16'd1);
    run_job("linear", 32'h0002_0040, 16'd16);
  endtask

  task automatic memory_stalls();
    stall_en <= 1'b1;
    run_job("mem_stall", 32'h0010_0000, 16'd24);
    stall_en <= 1'b0;
  endtask

  task automatic consumer_backpressure();
    bp_en <= 1'b1;
    run_job("backpressure", 32'h0030_0100, 16'd24);
    stall_en <= 1'b1;  // both sides random
    run_job("stall_and_bp", 32'h0031_0000, 16'd20);
    stall_en <= 1'b0;
    bp_en    <= 1'b0;
  endtask

  task automatic back_to_back_jobs();
    run_job("first_job", 32'h0040_0000, 16'd6);
    run_job("second_job", 32'h0050_0800, 16'd6);
  endtask

  // abort a long job, then a fresh one must run clean
  task automatic clear_mid_job();
    source_pkg::addr_t base;
    int                n0;
    int                n_clr;
    int                r_clr;
    base = 32'h0060_0000;
    n0   = got_q.size();
    start_job(base, 16'd40);
    while (got_q.size() < n0 + 3) @(posedge clk_i);
    gnt_block <= 1'b1;  // no new loads, the burst in flight drains
    repeat (4) @(posedge clk_i);
    clear_i <= 1'b1;
    @(posedge clk_i);
    clear_i   <= 1'b0;
    gnt_block <= 1'b0;
    n_clr = got_q.size();
    r_clr = req_cnt;
    repeat (20) @(posedge clk_i);
    check_value("clear beats", beat_t'(n_clr), beat_t'(got_q.size()));
    check_value("clear requests", beat_t'(r_clr), beat_t'(req_cnt));
    check_value("clear ready_start", beat_t'(1'b1), beat_t'(ready_start_o));
    for (int k = 0; k < n_clr - n0; k++)
      check_value("clear prefix data", expected_beat(base, k), got_q[n0 + k]);
    run_job("after_clear", 32'h0070_0010, 16'd10);
  endtask

`endif

//--- test/tb_stream_source.sv
// load engine testbench, clock, reset, memory model, stream monitor and closing report
`timescale 1ns/1ps
`include "source_settings.svh"

module tb_stream_source;

  localparam int                NB         = `SRC_NB_PORTS;
  localparam int                BEAT_W     = `SRC_NB_PORTS * `SRC_WORD_W;
  localparam int unsigned       MAX_CYCLES = 20000;         // tests take under 2000
  localparam logic [31:0]       SEED       = 32'h07e9_31d1;
  localparam source_pkg::word_t PATTERN    = 32'hA5A5_0000; // memory word = address xor this

  typedef logic [BEAT_W-1:0] beat_t;

  logic                       clk_i;
  logic                       rst_ni;
  logic                       clear_i;
  logic                       start_i;
  source_pkg::addr_t          base_addr_i;
  source_pkg::count_t         trans_size_i;
  logic                       ready_start_o;
  logic                       done_o;
  logic [NB-1:0]              mem_req_o;
  source_pkg::addr_t [NB-1:0] mem_addr_o;
  logic [NB-1:0]              mem_gnt_i    = '1;
  logic [NB-1:0]              mem_rvalid_i = '0;
  source_pkg::word_t [NB-1:0] mem_rdata_i  = '0;
  logic                       valid_o;
  beat_t                      data_o;
  logic                       ready_i      = 1'b1;

  // test modes
  logic stall_en  = 1'b0;  // random grants
  logic bp_en     = 1'b0;  // random consumer ready
  logic gnt_block = 1'b0;  // all grants held low

  // monitor state
  beat_t       got_q[$];            // beats taken by the consumer, in order
  int          done_cnt     = 0;
  int          req_cnt      = 0;    // cycles with a request
  int          mon_err_cnt  = 0;
  int          err_cnt      = 0;    // value mismatches
  logic        hold_pending = 1'b0; // beat stalled last cycle
  beat_t       hold_data;
  int unsigned cycle_cnt    = 0;

  stream_source i_stream_source (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .clear_i       ( clear_i       ),
    .start_i       ( start_i       ),
    .base_addr_i   ( base_addr_i   ),
    .trans_size_i  ( trans_size_i  ),
    .ready_start_o ( ready_start_o ),
    .done_o        ( done_o        ),
    .mem_req_o     ( mem_req_o     ),
    .mem_addr_o    ( mem_addr_o    ),
    .mem_gnt_i     ( mem_gnt_i     ),
    .mem_rvalid_i  ( mem_rvalid_i  ),
    .mem_rdata_i   ( mem_rdata_i   ),
    .valid_o       ( valid_o       ),
    .data_o        ( data_o        ),
    .ready_i       ( ready_i       )
  );

  `include "tb_stream_source_tasks.svh"

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;  // 4 ns period
  end

  // memory, answers every granted burst one cycle later
  always @(posedge clk_i) begin
    mem_rvalid_i <= '0;
    if ((mem_req_o & mem_gnt_i) != '0) begin
      mem_rvalid_i <= '1;
      for (int p = 0; p < NB; p++) begin
        mem_rdata_i[p] <= mem_addr_o[p] ^ PATTERN;
      end
    end
  end

  // grant and consumer ready, same grant on all ports
  always @(posedge clk_i) begin
    if (gnt_block)
      mem_gnt_i <= '0;
    else if (stall_en)
      mem_gnt_i <= {NB{($urandom % 3) == 0}};
    else
      mem_gnt_i <= '1;
    ready_i <= bp_en ? (($urandom % 3) != 0) : 1'b1;
  end

  // stream monitor, mid-cycle so all inputs have settled
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (valid_o && ready_i)
        got_q.push_back(data_o);
      if (|mem_req_o)
        req_cnt++;
      if (done_o) begin
        done_cnt++;
        if (!ready_start_o) begin
          mon_err_cnt++;
          $display("ready_start_o is low while done_o is high at %0t", $time);
        end
      end
      if ((|mem_req_o) && !ready_i) begin
        mon_err_cnt++;
        $display("memory request issued while ready_i is low at %0t", $time);
      end
      if (hold_pending && !valid_o) begin
        mon_err_cnt++;
        $display("valid_o dropped before the beat was taken at %0t", $time);
      end else if (hold_pending && data_o !== hold_data) begin
        mon_err_cnt++;
        $display("data_o changed while the beat was stalled at %0t", $time);
      end
      hold_pending = valid_o && !ready_i;
      hold_data    = data_o;
    end else begin
      hold_pending = 1'b0;
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == MAX_CYCLES) begin
      $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
      $display("errors: %0d in checks, %0d in monitor", err_cnt, mon_err_cnt);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(SEED));  // single seed for the run
    rst_ni       = 1'b0;
    clear_i      = 1'b0;
    start_i      = 1'b0;
    base_addr_i  = '0;
    trans_size_i = '0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    reset_outputs();
    basic_jobs();
    memory_stalls();
    consumer_backpressure();
    back_to_back_jobs();
    clear_mid_job();
    $display("errors: %0d in checks, %0d in monitor", err_cnt, mon_err_cnt);
    if (err_cnt == 0 && mon_err_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+common
+incdir+test
common/source_pkg.sv
src/source_fsm.sv
src/source_addressgen.sv
src/load_port_buffer.sv
src/word_merge.sv
src/stream_source.sv
test/tb_stream_source.sv

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  -f project.f \
  --top-module tb_stream_source \
  -Mdir build

./build/Vtb_stream_source > sim.log 2>&1
cat sim.log

if grep -q "^Test passed$" sim.log; then
  exit 0
else
  exit 1
fi
